// File: slc3_params.svh
`ifndef SLC3_PARAMS_SVH
`define SLC3_PARAMS_SVH

// ----------------------------------------------------------------------
// Machine dimensions
// ----------------------------------------------------------------------

// Data and address width
`define SLC3_WORD 16

// General purpose registers R0 to R7
`define SLC3_NUM_REGS 8

// ----------------------------------------------------------------------
// Memory interface
// ----------------------------------------------------------------------

// Cycles that oe or we stays high for one SRAM access
`define SLC3_MEM_WAIT 3

// Switches on read, hex display on write
`define SLC3_IO_ADDR 16'hFFFF

`endif

// File: slc3IsaPkg.sv
package slc3IsaPkg;

	// ------------------------------------------------------------------
	// Opcodes of the supported LC-3 subset
	// ------------------------------------------------------------------
	typedef enum logic [3:0] {
		opBr    = 4'b0000,
		opAdd   = 4'b0001,
		opAnd   = 4'b0101,
		opLdr   = 4'b0110,
		opStr   = 4'b0111,
		opNot   = 4'b1001,
		opJmp   = 4'b1100,
		opPause = 4'b1101
	} opcodeT;

	// ADD, AND, NOT and JMP layout
	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] dr;
		logic [2:0] sr1;
		// High selects the 5-bit immediate
		logic       immFlag;
		// imm5, or SR2 in the low three bits
		logic [4:0] immOrSr2;
	} operateFmtT;

	// LDR and STR layout
	typedef struct packed {
		opcodeT     opcode;
		logic [2:0] dataReg;
		logic [2:0] baseReg;
		logic [5:0] offset6;
	} memFmtT;

	// BR layout
	typedef struct packed {
		opcodeT     opcode;
		logic       n;
		logic       z;
		logic       p;
		logic [8:0] offset9;
	} branchFmtT;

	// One IR word, three decodings
	typedef union packed {
		operateFmtT op;
		memFmtT     mem;
		branchFmtT  br;
	} instrU;

endpackage

// File: slc3CtrlPkg.sv
package slc3CtrlPkg;

	// Control unit states
	typedef enum logic [4:0] {
		sHalted,
		sFetchAddr,
		sFetchWait,
		sFetchLoad,
		sDecode,
		sExecAlu,
		sExecBr,
		sExecJmp,
		sMemAddr,
		sMemWait,
		sMemLoad,
		sStoreData,
		sStoreWait,
		sPauseLed,
		sPauseWait,
		sPauseRelease
	} isduStateT;

	// Source driving the internal bus
	typedef enum logic [1:0] {
		busPc,
		busMdr,
		busAlu,
		busAddr
	} busSelT;

	// Next PC source
	typedef enum logic [1:0] {
		pcInc,
		pcBus,
		pcAddr
	} pcSelT;

	// ALU function
	typedef enum logic [1:0] {
		aluAdd,
		aluAnd,
		aluNot,
		aluPass
	} aluOpT;

endpackage

// File: hexDriver.sv
module hexDriver (
	input  logic [3:0] nibble,
	output logic [6:0] segments
);

	// Active low, bit order gfedcba
	always_comb begin
		case (nibble)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			4'hA: segments = 7'b0001000;
			4'hB: segments = 7'b0000011;
			4'hC: segments = 7'b1000110;
			4'hD: segments = 7'b0100001;
			4'hE: segments = 7'b0000110;
			default: segments = 7'b0001110;
		endcase
	end

endmodule

// File: slc3Datapath.sv
`include "slc3_params.svh"

module slc3Datapath (
	input  logic                   Clk,
	input  logic                   rst,
	input  logic                   ldMar,
	input  logic                   ldMdr,
	input  logic                   ldIr,
	input  logic                   ldBen,
	input  logic                   ldCc,
	input  logic                   ldReg,
	input  logic                   ldPc,
	input  logic                   ldLed,
	input  slc3CtrlPkg::busSelT    busSel,
	input  slc3CtrlPkg::pcSelT     pcSel,
	input  slc3CtrlPkg::aluOpT     aluOp,
	input  logic                   drSelIr11,
	input  logic                   sr1SelIr11,
	input  logic                   addr1SelPc,
	input  logic [1:0]             addr2Sel,
	input  logic                   mioEn,
	input  logic [`SLC3_WORD-1:0]  dataToCpu,
	output slc3IsaPkg::instrU      ir,
	output logic                   ben,
	output logic [`SLC3_WORD-1:0]  mar,
	output logic [`SLC3_WORD-1:0]  mdr,
	output logic [9:0]             led
);
	import slc3CtrlPkg::*;

	logic [`SLC3_WORD-1:0] pc;
	logic [`SLC3_WORD-1:0] regFile [`SLC3_NUM_REGS];
	logic flagN, flagZ, flagP;
	logic [`SLC3_WORD-1:0] bus;
	logic [`SLC3_WORD-1:0] sr1Data, aluB, aluOut;
	logic [`SLC3_WORD-1:0] addr1, addr2, addrSum;
	logic [2:0] drIdx, sr1Idx;

	// ------------------------------------------------------------------
	// Register selects and operands
	// ------------------------------------------------------------------
	// R7 as the alternate destination
	assign drIdx  = drSelIr11 ? ir.op.dr : 3'd7;
	// STR source lives in IR[11:9]
	assign sr1Idx = sr1SelIr11 ? ir.op.dr : ir.op.sr1;
	assign sr1Data = regFile[sr1Idx];

	// IR[5] picks sign-extended imm5 or SR2
	assign aluB = ir.op.immFlag ? `SLC3_WORD'(signed'(ir.op.immOrSr2))
		: regFile[ir.op.immOrSr2[2:0]];

	always_comb begin
		case (aluOp)
			aluAdd:  aluOut = sr1Data + aluB;
			aluAnd:  aluOut = sr1Data & aluB;
			aluNot:  aluOut = ~sr1Data;
			default: aluOut = sr1Data;
		endcase
	end

	// ------------------------------------------------------------------
	// Address adder
	// ------------------------------------------------------------------
	assign addr1 = addr1SelPc ? pc : sr1Data;

	always_comb begin
		case (addr2Sel)
			2'b01:   addr2 = `SLC3_WORD'(signed'(ir.mem.offset6));
			2'b10:   addr2 = `SLC3_WORD'(signed'(ir.br.offset9));
			default: addr2 = '0;
		endcase
	end

	assign addrSum = addr1 + addr2;

	// Single bus mux without tristates
	always_comb begin
		case (busSel)
			busPc:   bus = pc;
			busMdr:  bus = mdr;
			busAlu:  bus = aluOut;
			default: bus = addrSum;
		endcase
	end

	// ------------------------------------------------------------------
	// Control state registers
	// ------------------------------------------------------------------
	always_ff @(posedge Clk) begin
		if (rst) begin
			pc    <= '0;
			flagN <= 1'b0;
			flagZ <= 1'b0;
			flagP <= 1'b0;
			ben   <= 1'b0;
			led   <= '0;
		end else begin
			if (ldPc) begin
				case (pcSel)
					pcBus:   pc <= bus;
					pcAddr:  pc <= addrSum;
					default: pc <= pc + 1'b1;
				endcase
			end
			// Flags follow the value written back
			if (ldCc) begin
				flagN <= bus[`SLC3_WORD-1];
				flagZ <= (bus == '0);
				flagP <= ~bus[`SLC3_WORD-1] && (bus != '0);
			end
			if (ldBen)
				ben <= (ir.br.n & flagN) | (ir.br.z & flagZ) | (ir.br.p & flagP);
			// PAUSE shows IR[9:0]
			if (ldLed)
				led <= ir[9:0];
		end
	end

	// Payload registers and register file
	always_ff @(posedge Clk) begin
		if (ldMar)
			mar <= bus;
		if (ldMdr)
			mdr <= mioEn ? dataToCpu : bus;
		if (ldIr)
			ir <= bus;
		if (ldReg)
			regFile[drIdx] <= bus;
	end

	// Write-back always updates the flags and only takes ALU or MDR data
	assert property (@(posedge Clk) disable iff (rst)
		(ldReg || ldCc) |-> (ldReg && ldCc && (busSel inside {busAlu, busMdr})));

endmodule

// File: slc3Isdu.sv
`include "slc3_params.svh"

module slc3Isdu (
	input  logic                Clk,
	input  logic                rst,
	input  logic                run,
	input  logic                resume,
	input  slc3IsaPkg::instrU   ir,
	input  logic                ben,
	output logic                ldMar,
	output logic                ldMdr,
	output logic                ldIr,
	output logic                ldBen,
	output logic                ldCc,
	output logic                ldReg,
	output logic                ldPc,
	output logic                ldLed,
	output slc3CtrlPkg::busSelT busSel,
	output slc3CtrlPkg::pcSelT  pcSel,
	output slc3CtrlPkg::aluOpT  aluOp,
	output logic                drSelIr11,
	output logic                sr1SelIr11,
	output logic                addr1SelPc,
	output logic [1:0]          addr2Sel,
	output logic                mioEn,
	output logic                oe,
	output logic                memWe
);
	import slc3IsaPkg::*;
	import slc3CtrlPkg::*;

	isduStateT state, nextState;
	logic [$clog2(`SLC3_MEM_WAIT + 1)-1:0] waitCnt;
	logic lastWait;

	// Final cycle of a fixed memory wait
	assign lastWait = (waitCnt == $bits(waitCnt)'(`SLC3_MEM_WAIT - 1));

	// ------------------------------------------------------------------
	// State and wait counter
	// ------------------------------------------------------------------
	always_ff @(posedge Clk) begin
		if (rst) begin
			state   <= sHalted;
			waitCnt <= '0;
		end else begin
			state <= nextState;
			if ((state inside {sFetchWait, sMemWait, sStoreWait}) && !lastWait)
				waitCnt <= waitCnt + 1'b1;
			else
				waitCnt <= '0;
		end
	end

	// ------------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------------
	always_comb begin
		nextState = state;
		case (state)
			sHalted:    if (run) nextState = sFetchAddr;
			sFetchAddr: nextState = sFetchWait;
			sFetchWait: if (lastWait) nextState = sFetchLoad;
			sFetchLoad: nextState = sDecode;
			sDecode: begin
				case (ir.op.opcode)
					opAdd, opAnd, opNot: nextState = sExecAlu;
					opBr:                nextState = sExecBr;
					opJmp:               nextState = sExecJmp;
					opLdr, opStr:        nextState = sMemAddr;
					opPause:             nextState = sPauseLed;
					// Unsupported opcode acts as a no-op
					default:             nextState = sFetchAddr;
				endcase
			end
			sMemAddr:      nextState = (ir.mem.opcode == opLdr) ? sMemWait : sStoreData;
			sMemWait:      if (lastWait) nextState = sMemLoad;
			sStoreData:    nextState = sStoreWait;
			sStoreWait:    if (lastWait) nextState = sFetchAddr;
			sPauseLed:     nextState = sPauseWait;
			sPauseWait:    if (resume) nextState = sPauseRelease;
			sPauseRelease: if (!resume) nextState = sFetchAddr;
			default:       nextState = sFetchAddr;
		endcase
	end

	// ------------------------------------------------------------------
	// Outputs per state
	// ------------------------------------------------------------------
	always_comb begin
		ldMar = 1'b0;
		ldMdr = 1'b0;
		ldIr  = 1'b0;
		ldBen = 1'b0;
		ldCc  = 1'b0;
		ldReg = 1'b0;
		ldPc  = 1'b0;
		ldLed = 1'b0;
		busSel = busPc;
		pcSel  = pcInc;
		aluOp  = aluPass;
		drSelIr11  = 1'b1;
		sr1SelIr11 = 1'b0;
		addr1SelPc = 1'b0;
		addr2Sel   = 2'b00;
		mioEn = 1'b0;
		oe    = 1'b0;
		memWe = 1'b0;
		case (state)
			// MAR <- PC, PC <- PC + 1
			sFetchAddr: begin
				ldMar = 1'b1;
				ldPc  = 1'b1;
			end
			sFetchWait, sMemWait: begin
				oe = 1'b1;
				// Capture read data at the end of the wait
				ldMdr = lastWait;
				mioEn = lastWait;
			end
			sFetchLoad: begin
				busSel = busMdr;
				ldIr   = 1'b1;
			end
			sDecode: ldBen = 1'b1;
			sExecAlu: begin
				busSel = busAlu;
				ldReg  = 1'b1;
				ldCc   = 1'b1;
				case (ir.op.opcode)
					opAdd:   aluOp = aluAdd;
					opAnd:   aluOp = aluAnd;
					default: aluOp = aluNot;
				endcase
			end
			// PC <- PC + offset9 when taken
			sExecBr: begin
				ldPc       = ben;
				pcSel      = pcAddr;
				addr1SelPc = 1'b1;
				addr2Sel   = 2'b10;
			end
			// PC <- BaseR through the ALU
			sExecJmp: begin
				busSel = busAlu;
				pcSel  = pcBus;
				ldPc   = 1'b1;
			end
			// MAR <- BaseR + offset6
			sMemAddr: begin
				busSel   = busAddr;
				addr2Sel = 2'b01;
				ldMar    = 1'b1;
			end
			sMemLoad: begin
				busSel = busMdr;
				ldReg  = 1'b1;
				ldCc   = 1'b1;
			end
			// MDR <- SR from IR[11:9]
			sStoreData: begin
				busSel     = busAlu;
				sr1SelIr11 = 1'b1;
				ldMdr      = 1'b1;
			end
			sStoreWait: memWe = 1'b1;
			sPauseLed:  ldLed = 1'b1;
			default: ;
		endcase
	end

	// Write strobe held for the full wait and never during a read
	assert property (@(posedge Clk) disable iff (rst)
		$rose(memWe) |-> (memWe && !oe) [*`SLC3_MEM_WAIT] ##1 !memWe);

	// Read data captured only after the full wait
	assert property (@(posedge Clk) disable iff (rst)
		(ldMdr && mioEn) |-> (oe && $past(oe, `SLC3_MEM_WAIT - 1)
			&& !$past(oe, `SLC3_MEM_WAIT)));

endmodule

// File: slc3Mem2Io.sv
`include "slc3_params.svh"

module slc3Mem2Io (
	input  logic                  Clk,
	input  logic                  rst,
	input  logic [`SLC3_WORD-1:0] addr,
	input  logic                  oe,
	input  logic                  memWe,
	input  logic [9:0]            sw,
	input  logic [`SLC3_WORD-1:0] dataFromCpu,
	input  logic [`SLC3_WORD-1:0] dataFromSram,
	output logic                  we,
	output logic [`SLC3_WORD-1:0] dataToCpu,
	output logic [`SLC3_WORD-1:0] dataToSram,
	output logic [`SLC3_WORD-1:0] hexData
);

	logic ioSel;
	// Write strobe one cycle back, marks the first write cycle
	logic memWeQ;

	assign ioSel = (addr == `SLC3_IO_ADDR);

	// ------------------------------------------------------------------
	// Read steering
	// ------------------------------------------------------------------
	// Switches zero-extended at the IO address
	always_comb begin
		if (!oe)
			dataToCpu = '0;
		else if (ioSel)
			dataToCpu = `SLC3_WORD'(sw);
		else
			dataToCpu = dataFromSram;
	end

	// ------------------------------------------------------------------
	// Write steering
	// ------------------------------------------------------------------
	assign dataToSram = dataFromCpu;
	// No SRAM write at the IO address
	assign we = memWe && !ioSel;

	always_ff @(posedge Clk) begin
		if (rst) begin
			memWeQ  <= 1'b0;
			hexData <= '0;
		end else begin
			memWeQ <= memWe;
			if (memWe && !memWeQ && ioSel)
				hexData <= dataFromCpu;
		end
	end

endmodule

// File: slc3.sv
`include "slc3_params.svh"

module slc3 (
	input  logic                  Clk,
	input  logic                  rst,
	input  logic                  run,
	input  logic                  resume,
	input  logic [9:0]            sw,
	input  logic [`SLC3_WORD-1:0] dataFromSram,
	output logic [9:0]            led,
	output logic                  oe,
	output logic                  we,
	output logic [`SLC3_WORD-1:0] addr,
	output logic [`SLC3_WORD-1:0] dataToSram,
	output logic [6:0]            hex0,
	output logic [6:0]            hex1,
	output logic [6:0]            hex2,
	output logic [6:0]            hex3
);
	import slc3IsaPkg::*;
	import slc3CtrlPkg::*;

	// ------------------------------------------------------------------
	// Control unit to datapath
	// ------------------------------------------------------------------
	logic ldMar, ldMdr, ldIr, ldBen, ldCc, ldReg, ldPc, ldLed;
	busSelT busSel;
	pcSelT pcSel;
	aluOpT aluOp;
	logic drSelIr11, sr1SelIr11, addr1SelPc;
	logic [1:0] addr2Sel;
	logic mioEn, memWe;
	instrU ir;
	logic ben;

	// Datapath and bridge
	logic [`SLC3_WORD-1:0] mdr, dataToCpu, hexData;

	slc3Datapath datapath (
		.Clk, .rst,
		.ldMar, .ldMdr, .ldIr, .ldBen, .ldCc, .ldReg, .ldPc, .ldLed,
		.busSel, .pcSel, .aluOp,
		.drSelIr11, .sr1SelIr11, .addr1SelPc, .addr2Sel,
		.mioEn, .dataToCpu,
		.ir, .ben, .mar(addr), .mdr, .led
	);

	slc3Isdu isdu (
		.Clk, .rst, .run, .resume, .ir, .ben,
		.ldMar, .ldMdr, .ldIr, .ldBen, .ldCc, .ldReg, .ldPc, .ldLed,
		.busSel, .pcSel, .aluOp,
		.drSelIr11, .sr1SelIr11, .addr1SelPc, .addr2Sel,
		.mioEn, .oe, .memWe
	);

	// MAR addresses both SRAM and the IO word
	slc3Mem2Io mem2Io (
		.Clk, .rst, .addr, .oe, .memWe, .sw,
		.dataFromCpu(mdr), .dataFromSram,
		.we, .dataToCpu, .dataToSram, .hexData
	);

	// One digit per nibble of the display register
	hexDriver hexDrv0 (.nibble(hexData[3:0]),   .segments(hex0));
	hexDriver hexDrv1 (.nibble(hexData[7:4]),   .segments(hex1));
	hexDriver hexDrv2 (.nibble(hexData[11:8]),  .segments(hex2));
	hexDriver hexDrv3 (.nibble(hexData[15:12]), .segments(hex3));

endmodule

// File: slc3TbSram.sv
`include "slc3_params.svh"

module slc3TbSram (
	input  logic                  oe,
	input  logic                  we,
	input  logic [`SLC3_WORD-1:0] addr,
	input  logic [`SLC3_WORD-1:0] dataIn,
	output logic [`SLC3_WORD-1:0] dataOut
);

	// Full 64K word array
	logic [`SLC3_WORD-1:0] mem [0:65535];

	// ------------------------------------------------------------------
	// Asynchronous port
	// ------------------------------------------------------------------
	// Read data follows the address while oe is high
	assign dataOut = oe ? mem[addr] : 'x;

	// Write completes at the end of the we pulse
	// Address and data are still held by the CPU then
	always @(negedge we) begin
		mem[addr] = dataIn;
	end

	// ------------------------------------------------------------------
	// Backdoor access
	// ------------------------------------------------------------------
	// Program and data loader, one word per call
	task automatic writeWord(
		input logic [`SLC3_WORD-1:0] a,
		input logic [`SLC3_WORD-1:0] d
	);
		mem[a] = d;
	endtask

	// Read one word without touching the port
	task automatic peek(
		input  logic [`SLC3_WORD-1:0] a,
		output logic [`SLC3_WORD-1:0] d
	);
		d = mem[a];
	endtask

endmodule

// File: slc3Tb.sv
`include "slc3_params.svh"

module slc3Tb;

	// Instruction budgets per test that also size the watchdog
	localparam int clkPeriod = 40;
	localparam int limArith  = 40;
	localparam int limLoop   = 120;
	localparam int limSw     = 20;
	localparam int limPause  = 30;
	localparam int limHex    = 20;
	// Loop budget counted three times as the reset test runs it twice
	localparam int limTotal  = limArith + 3 * limLoop + limSw + 2 * limPause + limHex;

	// LC-3 opcodes
	localparam logic [3:0] codeBr    = 4'b0000;
	localparam logic [3:0] codeAdd   = 4'b0001;
	localparam logic [3:0] codeAnd   = 4'b0101;
	localparam logic [3:0] codeLdr   = 4'b0110;
	localparam logic [3:0] codeStr   = 4'b0111;
	localparam logic [3:0] codeNot   = 4'b1001;
	localparam logic [3:0] codeJmp   = 4'b1100;
	localparam logic [3:0] codePause = 4'b1101;

	logic Clk, rst, run, resume;
	logic [9:0] sw, led, swVal;
	logic oe, we;
	logic [`SLC3_WORD-1:0] dataFromSram, addr, dataToSram;
	logic [6:0] hex0, hex1, hex2, hex3;

	// Program image and the memory the reference model evolves
	logic [15:0] image  [0:65535];
	logic [15:0] expMem [0:65535];
	logic [15:0] prog [$];
	logic [9:0]  expLed [$];
	logic [15:0] expHex;

	string testName;
	int testErrors, passCount, failCount;
	// Request to the checker
	int pauseIdx, checkLimit;
	bit finalCheck;
	event startCheck, checkDone;

	slc3 dut (
		.Clk, .rst, .run, .resume, .sw, .dataFromSram,
		.led, .oe, .we, .addr, .dataToSram,
		.hex0, .hex1, .hex2, .hex3
	);

	slc3TbSram sram (.oe, .we, .addr, .dataIn(dataToSram), .dataOut(dataFromSram));

	always #(clkPeriod / 2) Clk = ~Clk;

	// ------------------------------------------------------------------
	// Instruction encoding
	// ------------------------------------------------------------------
	function automatic logic [15:0] regOp(input logic [3:0] op, input int dr, input int sr1,
		input int sr2);
		return {op, dr[2:0], sr1[2:0], 3'b000, sr2[2:0]};
	endfunction

	function automatic logic [15:0] immOp(input logic [3:0] op, input int dr, input int sr1,
		input int imm);
		return {op, dr[2:0], sr1[2:0], 1'b1, imm[4:0]};
	endfunction

	// LDR and STR
	function automatic logic [15:0] memOp(input logic [3:0] op, input int r, input int base,
		input int off);
		return {op, r[2:0], base[2:0], off[5:0]};
	endfunction

	function automatic logic [15:0] notInstr(input int dr, input int sr);
		return {codeNot, dr[2:0], sr[2:0], 6'b111111};
	endfunction

	function automatic logic [15:0] branchInstr(input logic [2:0] nzp, input int off);
		return {codeBr, nzp, off[8:0]};
	endfunction

	function automatic logic [15:0] jumpInstr(input int base);
		return {codeJmp, 3'b000, base[2:0], 6'b000000};
	endfunction

	function automatic logic [15:0] pauseInstr(input logic [9:0] code);
		return {codePause, 2'b00, code};
	endfunction

	// Lit segments gfedcba inverted for the active-low display
	function automatic logic [6:0] segFor(input logic [3:0] v);
		case (v)
			4'h0: return ~7'h3F;
			4'h1: return ~7'h06;
			4'h2: return ~7'h5B;
			4'h3: return ~7'h4F;
			4'h4: return ~7'h66;
			4'h5: return ~7'h6D;
			4'h6: return ~7'h7D;
			4'h7: return ~7'h07;
			4'h8: return ~7'h7F;
			4'h9: return ~7'h6F;
			4'hA: return ~7'h77;
			4'hB: return ~7'h7C;
			4'hC: return ~7'h39;
			4'hD: return ~7'h5E;
			4'hE: return ~7'h79;
			default: return ~7'h71;
		endcase
	endfunction

	// ------------------------------------------------------------------
	// ISA reference model
	// ------------------------------------------------------------------
	// Runs expMem until nPauses PAUSE instructions or the step limit
	function automatic void runIsa(input logic [9:0] swIn, input int nPauses, input int limit);
		logic [15:0] r [8];
		logic [15:0] pc, instr, val, ea, opB;
		logic n, z, p;
		int steps, pauses;
		foreach (r[i])
			r[i] = '0;
		pc = '0;
		n = 1'b0;
		z = 1'b0;
		p = 1'b0;
		pauses = 0;
		expLed.delete();
		expHex = '0;
		for (steps = 0; steps < limit && pauses < nPauses; steps++) begin
			instr = expMem[pc];
			pc = pc + 1'b1;
			// imm5 or SR2 and the BaseR + offset6 address
			opB = instr[5] ? {{11{instr[4]}}, instr[4:0]} : r[instr[2:0]];
			ea = r[instr[8:6]] + {{10{instr[5]}}, instr[5:0]};
			val = '0;
			case (instr[15:12])
				codeAdd: val = r[instr[8:6]] + opB;
				codeAnd: val = r[instr[8:6]] & opB;
				codeNot: val = ~r[instr[8:6]];
				// Switches appear zero-extended at the IO word
				codeLdr: val = (ea == `SLC3_IO_ADDR) ? {6'b0, swIn} : expMem[ea];
				codeStr: begin
					if (ea == `SLC3_IO_ADDR)
						expHex = r[instr[11:9]];
					else
						expMem[ea] = r[instr[11:9]];
				end
				codeBr: begin
					if ((instr[11] & n) | (instr[10] & z) | (instr[9] & p))
						pc = pc + {{7{instr[8]}}, instr[8:0]};
				end
				codeJmp: pc = r[instr[8:6]];
				codePause: begin
					expLed.push_back(instr[9:0]);
					pauses++;
				end
				default: ;
			endcase
			// Write-back sets the condition codes
			if (instr[15:12] inside {codeAdd, codeAnd, codeNot, codeLdr}) begin
				r[instr[11:9]] = val;
				n = val[15];
				z = (val == '0);
				p = !val[15] && (val != '0);
			end
		end
	endfunction

	// ------------------------------------------------------------------
	// Image building and DUT control
	// ------------------------------------------------------------------
	task automatic buildBase();
		int a;
		prog.delete();
		for (a = 0; a < 65536; a++)
			image[a] = a[15:0] * 16'h9E37 + 16'h2B1D;
	endtask

	task automatic emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	// Program at address 0 then copied to SRAM and the reference memory
	task automatic loadImage();
		int a;
		foreach (prog[i])
			image[i] = prog[i];
		for (a = 0; a < 65536; a++) begin
			sram.writeWord(a[15:0], image[a]);
			expMem[a] = image[a];
		end
	endtask

	// Array sum over a BR loop then JMP over two stores
	task automatic buildLoop(input int minCount);
		int count;
		count = minCount + $urandom % (13 - minCount);
		image[16'hFFFE] = 16'h0200;
		image[16'hFFFD] = 16'(count);
		image[16'hFFFB] = 16'd14;
		for (int i = 0; i < count; i++)
			image[16'h0200 + i] = 16'($urandom);
		emit(immOp(codeAnd, 0, 0, 0));
		emit(immOp(codeAnd, 3, 3, 0));
		emit(memOp(codeLdr, 2, 0, -2));
		emit(memOp(codeLdr, 1, 0, -3));
		// Loop body at address 4
		emit(memOp(codeLdr, 4, 2, 0));
		emit(regOp(codeAdd, 3, 3, 4));
		emit(immOp(codeAdd, 2, 2, 1));
		emit(immOp(codeAdd, 1, 1, -1));
		emit(branchInstr(3'b001, -5));
		emit(memOp(codeStr, 3, 0, -4));
		emit(memOp(codeLdr, 5, 0, -5));
		emit(jumpInstr(5));
		// Skipped stores keep the markers at FFFA and FFF9
		emit(memOp(codeStr, 3, 0, -6));
		emit(memOp(codeStr, 3, 0, -7));
		emit(pauseInstr(10'h202));
	endtask

	task automatic resetDut(input bit reload);
		@(posedge Clk);
		rst <= 1'b1;
		repeat (16) @(posedge Clk);
		if (reload)
			loadImage();
		rst <= 1'b0;
	endtask

	task automatic startRun();
		@(posedge Clk);
		run <= 1'b1;
		@(posedge Clk);
		run <= 1'b0;
	endtask

	task automatic pulseResume();
		@(posedge Clk);
		resume <= 1'b1;
		repeat (2) @(posedge Clk);
		resume <= 1'b0;
	endtask

	// Hand one pause to the checker and wait for its verdict
	task automatic reachPause(input int idx, input bit isFinal, input int limit);
		pauseIdx = idx;
		finalCheck = isFinal;
		checkLimit = limit;
		-> startCheck;
		@(checkDone);
	endtask

	// No SRAM or IO traffic while paused
	task automatic expectQuiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			@(negedge Clk);
			assert (!oe && !we) else begin
				$display("%s: memory access while paused", testName);
				testErrors++;
			end
		end
	endtask

	task automatic finishTest();
		if (testErrors == 0) begin
			passCount++;
			$display("%s: ok", testName);
		end else begin
			failCount++;
			$display("%s: FAILED, %0d errors", testName, testErrors);
		end
		testErrors = 0;
	endtask

	// ------------------------------------------------------------------
	// Checker
	// ------------------------------------------------------------------
	task automatic compareValue(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		assert (act === exp) else begin
			if (testErrors < 20)
				$display("ERROR %s: expected %h, got %h", name, exp, act);
			testErrors++;
		end
	endtask

	// Pause seen as an LED change with the memory port idle
	task automatic waitPause(input int limit, output bit reached);
		logic [9:0] prevLed;
		prevLed = led;
		reached = 1'b0;
		for (int cyc = 0; cyc < limit * 10 && !reached; cyc++) begin
			@(negedge Clk);
			if (led !== prevLed && !oe && !we)
				reached = 1'b1;
		end
	endtask

	initial begin
		bit reached;
		logic [15:0] word;
		forever begin
			@(startCheck);
			waitPause(checkLimit, reached);
			assert (reached) else begin
				$display("%s: pause %0d was never reached", testName, pauseIdx);
				testErrors++;
			end
			if (reached) begin
				compareValue("led", expLed[pauseIdx], led);
				if (finalCheck) begin
					for (int a = 0; a < 65536; a++) begin
						sram.peek(a[15:0], word);
						compareValue($sformatf("mem[%04h]", a), expMem[a], word);
					end
					compareValue("hex0", segFor(expHex[3:0]), hex0);
					compareValue("hex1", segFor(expHex[7:4]), hex1);
					compareValue("hex2", segFor(expHex[11:8]), hex2);
					compareValue("hex3", segFor(expHex[15:12]), hex3);
				end
			end
			-> checkDone;
		end
	end

	// Summed budgets at ten cycles per instruction
	initial begin
		#(limTotal * 10 * clkPeriod);
		$display("watchdog expired before all tests finished");
		$display("sim failed");
		$finish;
	end

	// ------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------
	initial begin
		int imm1, imm2;
		logic [9:0] code;
		Clk = 1'b0;
		rst = 1'b1;
		run = 1'b0;
		resume = 1'b0;
		sw = '0;
		swVal = '0;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		void'($urandom(29802));

		// ALU forms on random operands
		testName = "alu ops";
		buildBase();
		image[16'hFFE0] = 16'($urandom);
		image[16'hFFE1] = 16'($urandom);
		imm1 = $urandom % 32;
		imm2 = $urandom % 32;
		emit(immOp(codeAnd, 0, 0, 0));
		emit(memOp(codeLdr, 1, 0, -32));
		emit(memOp(codeLdr, 2, 0, -31));
		emit(regOp(codeAdd, 3, 1, 2));
		emit(memOp(codeStr, 3, 0, -30));
		emit(immOp(codeAdd, 3, 1, imm1));
		emit(memOp(codeStr, 3, 0, -29));
		emit(regOp(codeAnd, 3, 1, 2));
		emit(memOp(codeStr, 3, 0, -28));
		emit(immOp(codeAnd, 3, 2, imm2));
		emit(memOp(codeStr, 3, 0, -27));
		// a - b through NOT and +1
		emit(notInstr(4, 2));
		emit(immOp(codeAdd, 4, 4, 1));
		emit(regOp(codeAdd, 4, 4, 1));
		emit(memOp(codeStr, 4, 0, -26));
		emit(pauseInstr(10'h101));
		resetDut(1'b1);
		runIsa(swVal, 1, limArith);
		startRun();
		reachPause(0, 1'b1, limArith);
		finishTest();

		testName = "branch loop";
		buildBase();
		buildLoop(1);
		resetDut(1'b1);
		runIsa(swVal, 1, limLoop);
		startRun();
		reachPause(0, 1'b1, limLoop);
		finishTest();

		// Switch read at the IO word
		testName = "switch read";
		buildBase();
		swVal = 10'($urandom);
		emit(immOp(codeAnd, 0, 0, 0));
		emit(memOp(codeLdr, 1, 0, -1));
		emit(memOp(codeStr, 1, 0, -32));
		emit(notInstr(2, 1));
		emit(memOp(codeStr, 2, 0, -31));
		emit(pauseInstr(10'h303));
		resetDut(1'b1);
		sw <= swVal;
		runIsa(swVal, 1, limSw);
		startRun();
		reachPause(0, 1'b1, limSw);
		finishTest();

		// Two pauses with distinct LED codes
		testName = "pause resume";
		buildBase();
		code = 10'h100 | 10'($urandom % 256);
		image[16'hFFE0] = 16'($urandom);
		emit(immOp(codeAnd, 0, 0, 0));
		emit(memOp(codeLdr, 1, 0, -32));
		emit(immOp(codeAdd, 1, 1, 5));
		emit(memOp(codeStr, 1, 0, -31));
		emit(pauseInstr(code));
		emit(regOp(codeAdd, 1, 1, 1));
		emit(memOp(codeStr, 1, 0, -30));
		emit(pauseInstr(code ^ 10'h200));
		resetDut(1'b1);
		runIsa(swVal, 2, 2 * limPause);
		startRun();
		reachPause(0, 1'b0, limPause);
		expectQuiet(20);
		pulseResume();
		reachPause(1, 1'b1, limPause);
		finishTest();

		// Store to the IO word drives the display only
		testName = "hex display";
		buildBase();
		image[16'hFFE0] = 16'($urandom);
		emit(immOp(codeAnd, 0, 0, 0));
		emit(memOp(codeLdr, 1, 0, -32));
		emit(memOp(codeStr, 1, 0, -1));
		emit(pauseInstr(10'h055));
		resetDut(1'b1);
		runIsa(swVal, 1, limHex);
		startRun();
		reachPause(0, 1'b1, limHex);
		finishTest();

		// Reset partway through the loop with memory kept
		testName = "mid-run reset";
		buildBase();
		buildLoop(6);
		resetDut(1'b1);
		runIsa(swVal, 1, limLoop);
		startRun();
		repeat (20 + $urandom % 40) @(posedge Clk);
		resetDut(1'b0);
		startRun();
		reachPause(0, 1'b1, limLoop);
		finishTest();

		$display("%0d tests ok, %0d tests failed", passCount, failCount);
		if (failCount == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: project.f
+incdir+.
slc3IsaPkg.sv
slc3CtrlPkg.sv
hexDriver.sv
slc3Datapath.sv
slc3Isdu.sv
slc3Mem2Io.sv
slc3.sv
slc3TbSram.sv
slc3Tb.sv

// File: Bender.yml
package:
  name: slc3

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - slc3IsaPkg.sv
      - slc3CtrlPkg.sv
      - hexDriver.sv
      - slc3Datapath.sv
      - slc3Isdu.sv
      - slc3Mem2Io.sv
      - slc3.sv
  - target: test
    include_dirs:
      - .
    files:
      - slc3TbSram.sv
      - slc3Tb.sv
